// ==== run.sh ====
#!/bin/sh
# build and run the bpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module tb_bpu -f verilog.f \
    -Mdir obj_dir -o tb_bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# result comes from the log, not only the exit code
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "bpu simulation passed"
    exit 0
else
    echo "bpu simulation failed, see sim.log"
    exit 1
fi

// ==== source/bpu.sv ====
`timescale 1ns/1ps

module bpu import bpu_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ready_i,
    input  logic                            flush_i,
    input  logic [31:0]                     redir_pc_i,
    // backend correction
    input  logic                            upd_valid_i,
    input  logic [31:0]                     upd_pc_i,
    input  logic [31:0]                     upd_target_i,
    input  bpu_br_type_e                    upd_br_type_i,
    input  logic                            upd_taken_i,
    input  logic [BPU_HISTORY_LEN-1:0]      upd_history_i,
    input  logic [1:0]                      upd_scnt_i,
    input  logic                            upd_type_miss_i,
    input  logic                            upd_target_miss_i,
    // prediction, one entry per slot
    output logic [31:0]                     pc_o,
    output logic [1:0]                      mask_o,
    output logic [1:0]                      taken_o,
    output logic [1:0][31:0]                target_o,
    output bpu_br_type_e [1:0]              br_type_o,
    output logic [1:0][1:0]                 scnt_o,
    output logic [1:0][BPU_HISTORY_LEN-1:0] history_o,
    output logic [1:0]                      need_update_o
);

    logic [1:0]         btb_hit;
    bpu_br_type_e [1:0] btb_type;
    logic [1:0][31:0]   btb_target;
    logic [31:0]        ras_top;

    bpu_btb btb_inst (
        .clk(clk), .rst_n(rst_n), .pc_i(pc_o),
        .hit_o(btb_hit), .br_type_o(btb_type), .target_o(btb_target),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_target_i(upd_target_i),
        .upd_br_type_i(upd_br_type_i), .upd_type_miss_i(upd_type_miss_i),
        .upd_target_miss_i(upd_target_miss_i)
    );

    bpu_dir_pred dir_pred_inst (
        .clk(clk), .rst_n(rst_n), .pc_i(pc_o),
        .history_o(history_o), .scnt_o(scnt_o),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_br_type_i(upd_br_type_i),
        .upd_taken_i(upd_taken_i), .upd_history_i(upd_history_i),
        .upd_scnt_i(upd_scnt_i), .upd_type_miss_i(upd_type_miss_i)
    );

    bpu_ras ras_inst (
        .clk(clk), .rst_n(rst_n),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_br_type_i(upd_br_type_i),
        .top_o(ras_top)
    );

    // counters feed the taken decision here as well as leaving on scnt_o
    bpu_pc_gen pc_gen_inst (
        .clk(clk), .rst_n(rst_n),
        .ready_i(ready_i), .flush_i(flush_i), .redir_pc_i(redir_pc_i),
        .hit_i(btb_hit), .btb_type_i(btb_type), .btb_target_i(btb_target),
        .scnt_i(scnt_o), .ras_top_i(ras_top),
        .pc_o(pc_o), .mask_o(mask_o), .taken_o(taken_o), .target_o(target_o),
        .br_type_o(br_type_o), .need_update_o(need_update_o)
    );

endmodule

// ==== source/bpu_btb.sv ====
`timescale 1ns/1ps

module bpu_btb import bpu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             pc_i,
    output logic [1:0]              hit_o,
    output bpu_br_type_e [1:0]      br_type_o,
    output logic [1:0][31:0]        target_o,
    input  logic                    upd_valid_i,
    input  logic [31:0]             upd_pc_i,
    input  logic [31:0]             upd_target_i,
    input  bpu_br_type_e            upd_br_type_i,
    input  logic                    upd_type_miss_i,
    input  logic                    upd_target_miss_i
);

    logic [BPU_BTB_LEN-1:0] rd_idx;
    logic [BPU_BTB_LEN-1:0] wr_idx;
    logic [BPU_TAG_LEN-1:0] rd_tag;
    logic                   wr_en;
    logic [1:0]             bank_we;
    bpu_btb_entry_t         rd_entry [2];
    bpu_btb_entry_t         wr_entry;

    assign rd_idx = bpu_hash(pc_i);
    assign rd_tag = bpu_tag(pc_i);
    assign wr_idx = bpu_hash(upd_pc_i);

    // only rewrite an entry when the backend saw it go wrong
    assign wr_en = upd_valid_i && (upd_type_miss_i || upd_target_miss_i);

    always_comb begin
        wr_entry.valid     = (upd_br_type_i != BR_NONE); // non-branch clears the slot
        wr_entry.tag       = bpu_tag(upd_pc_i);
        wr_entry.br_type   = upd_br_type_i;
        wr_entry.target_pc = upd_target_i;
    end

    // bank 0 holds slot 0 (pc[2]=0), bank 1 holds slot 1
    for (genvar i = 0; i < 2; i++) begin : g_bank
        assign bank_we[i] = wr_en && (upd_pc_i[2] == 1'(i));

        bpu_table #(
            .entry_t (bpu_btb_entry_t),
            .DEPTH   (BPU_BTB_DEPTH)
        ) bank_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .raddr_i (rd_idx),
            .rdata_o (rd_entry[i]),
            .we_i    (bank_we[i]),
            .waddr_i (wr_idx),
            .wdata_i (wr_entry)
        );

        assign hit_o[i]     = rd_entry[i].valid && (rd_entry[i].tag == rd_tag);
        assign br_type_o[i] = rd_entry[i].br_type;   // raw, pc_gen masks on miss
        assign target_o[i]  = rd_entry[i].target_pc;
    end

endmodule

// ==== source/bpu_dir_pred.sv ====
`timescale 1ns/1ps

// local history -> 2-bit counter direction predictor
module bpu_dir_pred import bpu_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [31:0]                      pc_i,
    output logic [1:0][BPU_HISTORY_LEN-1:0]  history_o,
    output logic [1:0][1:0]                  scnt_o,
    input  logic                             upd_valid_i,
    input  logic [31:0]                      upd_pc_i,
    input  bpu_br_type_e                     upd_br_type_i,
    input  logic                             upd_taken_i,
    input  logic [BPU_HISTORY_LEN-1:0]       upd_history_i,
    input  logic [1:0]                       upd_scnt_i,
    input  logic                             upd_type_miss_i
);

    // saturating step toward the resolved direction
    function automatic logic [1:0] sat_cnt(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && cnt != 2'b11) begin
            res = cnt + 2'd1;
        end else if (!taken && cnt != 2'b00) begin
            res = cnt - 2'd1;
        end
        return res;
    endfunction

    logic [BPU_BTB_LEN-1:0]      bht_ridx;
    logic [BPU_BTB_LEN-1:0]      bht_widx;
    logic [1:0][BPU_PHT_LEN-1:0] pht_ridx;  // differs per slot, history differs
    logic [BPU_PHT_LEN-1:0]      pht_widx;
    logic [1:0]                  bht_we;
    logic [1:0]                  pht_we;
    bpu_bht_entry_t              bht_rd [2];
    bpu_pht_entry_t              pht_rd [2];
    bpu_bht_entry_t              bht_wr;
    bpu_pht_entry_t              pht_wr;

    assign bht_ridx = bpu_hash(pc_i);      // same index as the btb
    assign bht_widx = bpu_hash(upd_pc_i);
    assign pht_widx = {upd_history_i, upd_pc_i[BPU_PHT_PC_LEN+2:3]}; // history the fetch saw

    // a fresh branch restarts its history, a known one shifts
    assign bht_wr.history = upd_type_miss_i ?
        {{(BPU_HISTORY_LEN-1){1'b0}}, upd_taken_i} :
        {upd_history_i[BPU_HISTORY_LEN-2:0], upd_taken_i};
    assign pht_wr.scnt = sat_cnt(upd_scnt_i, upd_taken_i);

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign bht_we[i] = upd_valid_i && (upd_pc_i[2] == 1'(i));
        assign pht_we[i] = bht_we[i] && (upd_br_type_i == BR_COND); // only cond trains pht

        bpu_table #(.entry_t(bpu_bht_entry_t), .DEPTH(BPU_BTB_DEPTH)) bht_inst (
            .clk(clk), .rst_n(rst_n),
            .raddr_i(bht_ridx), .rdata_o(bht_rd[i]),
            .we_i(bht_we[i]), .waddr_i(bht_widx), .wdata_i(bht_wr)
        );

        assign pht_ridx[i] = {bht_rd[i].history, pc_i[BPU_PHT_PC_LEN+2:3]};

        bpu_table #(.entry_t(bpu_pht_entry_t), .DEPTH(BPU_PHT_DEPTH)) pht_inst (
            .clk(clk), .rst_n(rst_n),
            .raddr_i(pht_ridx[i]), .rdata_o(pht_rd[i]),
            .we_i(pht_we[i]), .waddr_i(pht_widx), .wdata_i(pht_wr)
        );

        assign history_o[i] = bht_rd[i].history;
        assign scnt_o[i]    = pht_rd[i].scnt;
    end

endmodule

// ==== source/bpu_pc_gen.sv ====
`timescale 1ns/1ps

// fetch pc register plus per-slot taken / target / next pc selection
module bpu_pc_gen import bpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ready_i,
    input  logic               flush_i,
    input  logic [31:0]        redir_pc_i,
    input  logic [1:0]         hit_i,
    input  bpu_br_type_e [1:0] btb_type_i,
    input  logic [1:0][31:0]   btb_target_i,
    input  logic [1:0][1:0]    scnt_i,
    input  logic [31:0]        ras_top_i,
    output logic [31:0]        pc_o,
    output logic [1:0]         mask_o,
    output logic [1:0]         taken_o,
    output logic [1:0][31:0]   target_o,
    output bpu_br_type_e [1:0] br_type_o,
    output logic [1:0]         need_update_o
);

    logic [31:0]      pc_q;
    logic [31:0]      npc;
    logic [31:0]      seq_pc;  // next aligned packet
    logic [1:0][31:0] fall_pc; // per-slot fall-through
    logic [1:0]       taken;

    assign seq_pc     = {pc_q[31:3] + 29'd1, 3'b000};
    assign fall_pc[0] = {pc_q[31:3], 3'b100};
    assign fall_pc[1] = seq_pc;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        // unconditional types always go, cond follows the counter msb
        assign taken[i] = hit_i[i] && ((btb_type_i[i] != BR_COND) || scnt_i[i][1]);

        always_comb begin
            if (!taken[i]) begin
                target_o[i] = fall_pc[i];
            end else if (btb_type_i[i] == BR_RET) begin
                target_o[i] = ras_top_i; // returns come from the stack
            end else begin
                target_o[i] = btb_target_i[i];
            end
        end

        assign br_type_o[i]     = hit_i[i] ? btb_type_i[i] : BR_NONE;
        assign need_update_o[i] = !hit_i[i]; // unknown pc, backend must install it
    end

    assign taken_o = taken;

    // slot 0 dead when entering mid-packet, slot 1 dead behind a taken slot 0
    assign mask_o[0] = !pc_q[2];
    assign mask_o[1] = !(mask_o[0] && taken[0]);

    always_comb begin
        if (mask_o[0] && taken[0]) begin
            npc = target_o[0];
        end else if (taken[1]) begin
            npc = target_o[1];
        end else begin
            npc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc_q <= redir_pc_i; // backend redirect wins over ready
        end else if (ready_i) begin
            pc_q <= npc;
        end                     // else hold, consumer stalled
    end

    assign pc_o = pc_q;

endmodule

// ==== source/bpu_pkg.sv ====
package bpu_pkg;

    // fetch start address after reset
    localparam logic [31:0] BPU_INIT_PC = 32'h1c000000;

    // btb / bht indexing
    localparam int BPU_BTB_LEN   = 6;
    localparam int BPU_BTB_DEPTH = 1 << BPU_BTB_LEN; // entries per bank
    localparam int BPU_TAG_LEN   = 8;                // pc[19:12]

    // local history and pattern table
    localparam int BPU_HISTORY_LEN = 5;
    localparam int BPU_PHT_PC_LEN  = 3;                               // pc[5:3]
    localparam int BPU_PHT_LEN     = BPU_HISTORY_LEN + BPU_PHT_PC_LEN; // {history, pc}
    localparam int BPU_PHT_DEPTH   = 1 << BPU_PHT_LEN;

    // return address stack
    localparam int BPU_RAS_LEN   = 3;
    localparam int BPU_RAS_DEPTH = 1 << BPU_RAS_LEN;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_COND, // conditional, direction from pht
        BR_JUMP, // b, plain jirl
        BR_CALL, // bl
        BR_RET   // jirl back through ra
    } bpu_br_type_e;

    typedef struct packed {
        logic                   valid;
        logic [BPU_TAG_LEN-1:0] tag;
        bpu_br_type_e           br_type;
        logic [31:0]            target_pc;
    } bpu_btb_entry_t;

    typedef struct packed {
        logic [BPU_HISTORY_LEN-1:0] history; // newest outcome in bit 0
    } bpu_bht_entry_t;

    typedef struct packed {
        logic [1:0] scnt; // bit 1 set means predict taken
    } bpu_pht_entry_t;

    // folds pc[14:3] down to the table index
    function automatic logic [BPU_BTB_LEN-1:0] bpu_hash(input logic [31:0] pc);
        return pc[14:9] ^ pc[8:3];
    endfunction

    function automatic logic [BPU_TAG_LEN-1:0] bpu_tag(input logic [31:0] pc);
        return pc[BPU_TAG_LEN+12-1:12];
    endfunction

endpackage

// ==== source/bpu_ras.sv ====
`timescale 1ns/1ps

module bpu_ras import bpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         upd_valid_i,
    input  logic [31:0]  upd_pc_i,
    input  bpu_br_type_e upd_br_type_i,
    output logic [31:0]  top_o
);

    logic [31:0]            stack [BPU_RAS_DEPTH];
    logic [BPU_RAS_LEN-1:0] top_ptr; // newest pushed entry
    logic [BPU_RAS_LEN-1:0] w_ptr;   // next free slot, always top_ptr + 1
    logic                   push;
    logic                   pop;
    logic [31:0]            ret_addr;

    // trained only from resolved calls / returns
    assign push     = upd_valid_i && (upd_br_type_i == BR_CALL);
    assign pop      = upd_valid_i && (upd_br_type_i == BR_RET);
    assign ret_addr = upd_pc_i + 32'd4; // instruction after the call

    assign top_o = stack[top_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1; // empty, points one below slot 0
            w_ptr   <= '0;
        end else if (push) begin
            top_ptr <= w_ptr;
            w_ptr   <= w_ptr + 1'b1; // wraps over oldest on overflow
        end else if (pop) begin
            top_ptr <= top_ptr - 1'b1;
            w_ptr   <= top_ptr;
        end
    end

    // stack body, zeroed so an empty stack predicts 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BPU_RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            stack[w_ptr] <= ret_addr;
        end
    end

endmodule

// ==== source/bpu_table.sv ====
`timescale 1ns/1ps

// small lut-ram style table, one read port and one write port
module bpu_table #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output entry_t                   rdata_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i
);

    entry_t mem [DEPTH];

    assign rdata_o = mem[raddr_i]; // async read, same-cycle lookup

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0; // everything starts invalid / zero count
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== test/tb_bpu.sv ====
`timescale 1ns/1ps

module tb_bpu import bpu_pkg::*; ();

    typedef struct {
        logic                            ready;
        logic                            flush;
        logic [31:0]                     redir;
        logic                            uv;     // correction strobe
        logic [31:0]                     upc;
        logic [31:0]                     utgt;
        bpu_br_type_e                    utype;
        logic                            utaken;
        logic [BPU_HISTORY_LEN-1:0]      uhist;
        logic [1:0]                      uscnt;
        logic                            utm;
        logic                            ugm;
        logic [31:0]                     pc;     // expected after the edge
        logic [1:0]                      mask;
        logic [1:0]                      taken;
        logic [31:0]                     tgt0;
        logic [31:0]                     tgt1;
        bpu_br_type_e                    ty0;
        bpu_br_type_e                    ty1;
        logic [1:0]                      nu;     // need_update per slot
        logic [1:0][1:0]                 scnt;   // {slot 1, slot 0}
        logic [1:0][BPU_HISTORY_LEN-1:0] hist;
    } row_t;

    logic                             clk;
    logic                             rst_n;
    logic                             ready_i;
    logic                             flush_i;
    logic [31:0]                      redir_pc_i;
    logic                             upd_valid_i;
    logic [31:0]                      upd_pc_i;
    logic [31:0]                      upd_target_i;
    bpu_br_type_e                     upd_br_type_i;
    logic                             upd_taken_i;
    logic [BPU_HISTORY_LEN-1:0]       upd_history_i;
    logic [1:0]                       upd_scnt_i;
    logic                             upd_type_miss_i;
    logic                             upd_target_miss_i;
    logic [31:0]                      pc_o;
    logic [1:0]                       mask_o;
    logic [1:0]                       taken_o;
    logic [1:0][31:0]                 target_o;
    bpu_br_type_e [1:0]               br_type_o;
    logic [1:0][1:0]                  scnt_o;
    logic [1:0][BPU_HISTORY_LEN-1:0]  history_o;
    logic [1:0]                       need_update_o;

    row_t        rows [$];
    row_t        next_row;       // correction staged for the next fetch row
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0; // 0 until the table is built

    tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

    bpu bpu_inst (
        .clk(clk), .rst_n(rst_n),
        .ready_i(ready_i), .flush_i(flush_i), .redir_pc_i(redir_pc_i),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_target_i(upd_target_i),
        .upd_br_type_i(upd_br_type_i), .upd_taken_i(upd_taken_i),
        .upd_history_i(upd_history_i), .upd_scnt_i(upd_scnt_i),
        .upd_type_miss_i(upd_type_miss_i), .upd_target_miss_i(upd_target_miss_i),
        .pc_o(pc_o), .mask_o(mask_o), .taken_o(taken_o), .target_o(target_o),
        .br_type_o(br_type_o), .scnt_o(scnt_o), .history_o(history_o),
        .need_update_o(need_update_o)
    );

    task automatic clear_corr();
        next_row.uv     = 1'b0;
        next_row.upc    = '0;
        next_row.utgt   = '0;
        next_row.utype  = BR_NONE;
        next_row.utaken = 1'b0;
        next_row.uhist  = '0;
        next_row.uscnt  = '0;
        next_row.utm    = 1'b0;
        next_row.ugm    = 1'b0;
    endtask

    task automatic set_corr(input logic [31:0] pc, input logic [31:0] tgt,
                            input bpu_br_type_e typ, input logic taken,
                            input logic [BPU_HISTORY_LEN-1:0] hist, input logic [1:0] scnt,
                            input logic tm, input logic gm);
        next_row.uv     = 1'b1;
        next_row.upc    = pc;
        next_row.utgt   = tgt;
        next_row.utype  = typ;
        next_row.utaken = taken;
        next_row.uhist  = hist;
        next_row.uscnt  = scnt;
        next_row.utm    = tm;
        next_row.ugm    = gm;
    endtask

    // counters and histories expected on the next fetch row, zero unless staged
    task automatic expect_dir(input logic [1:0][1:0] scnt,
                              input logic [1:0][BPU_HISTORY_LEN-1:0] hist);
        next_row.scnt = scnt;
        next_row.hist = hist;
    endtask

    // one table row, picks up any staged correction
    task automatic add_fetch(input logic ready, input logic flush, input logic [31:0] redir,
                             input logic [31:0] pc, input logic [1:0] mask,
                             input logic [1:0] taken, input logic [31:0] tgt0,
                             input logic [31:0] tgt1, input bpu_br_type_e ty0,
                             input bpu_br_type_e ty1, input logic [1:0] nu);
        next_row.ready = ready;
        next_row.flush = flush;
        next_row.redir = redir;
        next_row.pc    = pc;
        next_row.mask  = mask;
        next_row.taken = taken;
        next_row.tgt0  = tgt0;
        next_row.tgt1  = tgt1;
        next_row.ty0   = ty0;
        next_row.ty1   = ty1;
        next_row.nu    = nu;
        rows.push_back(next_row);
        clear_corr();
        expect_dir('0, '0);
    endtask

    task automatic build_table();
        clear_corr();
        expect_dir('0, '0);
        // reset pc holds, tables empty
        add_fetch(0, 0, 0, 32'h1c000000, 2'b11, 2'b00, 32'h1c000004, 32'h1c000008,
                  BR_NONE, BR_NONE, 2'b11);
        add_fetch(1, 0, 0, 32'h1c000008, 2'b11, 2'b00, 32'h1c00000c, 32'h1c000010,
                  BR_NONE, BR_NONE, 2'b11); // +8 per ready cycle
        add_fetch(1, 0, 0, 32'h1c000010, 2'b11, 2'b00, 32'h1c000014, 32'h1c000018,
                  BR_NONE, BR_NONE, 2'b11);
        add_fetch(0, 0, 0, 32'h1c000010, 2'b11, 2'b00, 32'h1c000014, 32'h1c000018,
                  BR_NONE, BR_NONE, 2'b11); // stalled
        add_fetch(0, 0, 0, 32'h1c000010, 2'b11, 2'b00, 32'h1c000014, 32'h1c000018,
                  BR_NONE, BR_NONE, 2'b11);
        // flush into slot 1, only slot 1 live
        add_fetch(0, 1, 32'h1c000104, 32'h1c000104, 2'b10, 2'b00, 32'h1c000104,
                  32'h1c000108, BR_NONE, BR_NONE, 2'b11);
        add_fetch(1, 0, 0, 32'h1c000108, 2'b11, 2'b00, 32'h1c00010c, 32'h1c000110,
                  BR_NONE, BR_NONE, 2'b11); // realigned
        // jump in slot 1 of 1c000200
        set_corr(32'h1c000204, 32'h1c000800, BR_JUMP, 1, 5'b00000, 2'b00, 1, 0);
        add_fetch(0, 0, 0, 32'h1c000108, 2'b11, 2'b00, 32'h1c00010c, 32'h1c000110,
                  BR_NONE, BR_NONE, 2'b11);
        expect_dir({2'b00, 2'b00}, {5'b00001, 5'b00000}); // jump restarted its history
        add_fetch(0, 1, 32'h1c000200, 32'h1c000200, 2'b11, 2'b10, 32'h1c000204,
                  32'h1c000800, BR_NONE, BR_JUMP, 2'b01);
        add_fetch(1, 0, 0, 32'h1c000800, 2'b11, 2'b00, 32'h1c000804, 32'h1c000808,
                  BR_NONE, BR_NONE, 2'b11); // followed the jump
        // cond in slot 0, counter 01 -> 10 under history 00001
        set_corr(32'h1c000400, 32'h1c000900, BR_COND, 1, 5'b00001, 2'b01, 1, 0);
        add_fetch(0, 0, 0, 32'h1c000800, 2'b11, 2'b00, 32'h1c000804, 32'h1c000808,
                  BR_NONE, BR_NONE, 2'b11);
        expect_dir({2'b00, 2'b10}, {5'b00000, 5'b00001});
        add_fetch(0, 1, 32'h1c000400, 32'h1c000400, 2'b01, 2'b01, 32'h1c000900,
                  32'h1c000408, BR_COND, BR_NONE, 2'b10); // slot 1 killed
        add_fetch(1, 0, 0, 32'h1c000900, 2'b11, 2'b00, 32'h1c000904, 32'h1c000908,
                  BR_NONE, BR_NONE, 2'b11);
        // not taken, 10 -> 01, history shifts to 00010
        set_corr(32'h1c000400, 32'h1c000900, BR_COND, 0, 5'b00001, 2'b10, 0, 0);
        add_fetch(0, 0, 0, 32'h1c000900, 2'b11, 2'b00, 32'h1c000904, 32'h1c000908,
                  BR_NONE, BR_NONE, 2'b11);
        expect_dir({2'b00, 2'b00}, {5'b00000, 5'b00010}); // new history, untouched counter
        add_fetch(0, 1, 32'h1c000400, 32'h1c000400, 2'b11, 2'b00, 32'h1c000404,
                  32'h1c000408, BR_COND, BR_NONE, 2'b10);
        // same index as 1c000400, tag 08 instead of 00
        expect_dir({2'b00, 2'b00}, {5'b00000, 5'b00010}); // bht/pht are untagged
        add_fetch(0, 1, 32'h1c008400, 32'h1c008400, 2'b11, 2'b00, 32'h1c008404,
                  32'h1c008408, BR_NONE, BR_NONE, 2'b11);
        // outer call, inner call, then the ret pops the inner one
        set_corr(32'h1c000300, 32'h1c000a00, BR_CALL, 1, 5'b00000, 2'b00, 1, 0);
        expect_dir({2'b00, 2'b00}, {5'b00000, 5'b00010});
        add_fetch(0, 0, 0, 32'h1c008400, 2'b11, 2'b00, 32'h1c008404, 32'h1c008408,
                  BR_NONE, BR_NONE, 2'b11);
        set_corr(32'h1c000a04, 32'h1c000c00, BR_CALL, 1, 5'b00000, 2'b00, 1, 0);
        expect_dir({2'b00, 2'b00}, {5'b00000, 5'b00010});
        add_fetch(0, 0, 0, 32'h1c008400, 2'b11, 2'b00, 32'h1c008404, 32'h1c008408,
                  BR_NONE, BR_NONE, 2'b11);
        set_corr(32'h1c000c0c, 32'h1c000f00, BR_RET, 1, 5'b00000, 2'b00, 1, 0);
        expect_dir({2'b00, 2'b00}, {5'b00000, 5'b00010});
        add_fetch(0, 0, 0, 32'h1c008400, 2'b11, 2'b00, 32'h1c008404, 32'h1c008408,
                  BR_NONE, BR_NONE, 2'b11);
        expect_dir({2'b00, 2'b00}, {5'b00001, 5'b00000});
        add_fetch(0, 1, 32'h1c000c08, 32'h1c000c08, 2'b11, 2'b10, 32'h1c000c0c,
                  32'h1c000304, BR_NONE, BR_RET, 2'b01); // stack top, not btb target
        // back in the caller packet, the call in slot 0 is dead but still hits
        // its pht index {00001, 000} is the counter left at 01 by the not-taken fix
        expect_dir({2'b00, 2'b01}, {5'b00000, 5'b00001});
        add_fetch(1, 0, 0, 32'h1c000304, 2'b10, 2'b01, 32'h1c000a00, 32'h1c000308,
                  BR_CALL, BR_NONE, 2'b10);
        add_fetch(1, 0, 0, 32'h1c000308, 2'b11, 2'b00, 32'h1c00030c, 32'h1c000310,
                  BR_NONE, BR_NONE, 2'b11);
    endtask

    task automatic apply_row(input row_t r);
        ready_i           = r.ready;
        flush_i           = r.flush;
        redir_pc_i        = r.redir;
        upd_valid_i       = r.uv;
        upd_pc_i          = r.upc;
        upd_target_i      = r.utgt;
        upd_br_type_i     = r.utype;
        upd_taken_i       = r.utaken;
        upd_history_i     = r.uhist;
        upd_scnt_i        = r.uscnt;
        upd_type_miss_i   = r.utm;
        upd_target_miss_i = r.ugm;
    endtask

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, field, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_row(input int idx, input row_t r);
        string pre;
        pre = $sformatf("row %0d", idx);
        check_value({pre, " pc_o"}, pc_o, r.pc);
        check_value({pre, " mask_o"}, 32'(mask_o), 32'(r.mask));
        check_value({pre, " taken_o"}, 32'(taken_o), 32'(r.taken));
        check_value({pre, " target_o[0]"}, target_o[0], r.tgt0);
        check_value({pre, " target_o[1]"}, target_o[1], r.tgt1);
        check_value({pre, " br_type_o[0]"}, 32'(br_type_o[0]), 32'(r.ty0));
        check_value({pre, " br_type_o[1]"}, 32'(br_type_o[1]), 32'(r.ty1));
        check_value({pre, " need_update_o"}, 32'(need_update_o), 32'(r.nu));
        check_value({pre, " scnt_o"}, 32'(scnt_o), 32'(r.scnt));
        check_value({pre, " history_o"}, 32'(history_o), 32'(r.hist));
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        clear_corr();
        next_row.ready = 1'b0;
        next_row.flush = 1'b0;
        next_row.redir = '0;
        apply_row(next_row);  // every input defined from time 0
        build_table();
        cycle_limit = rows.size() * 2 + 20 + 50;
        @(posedge rst_n);
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);  // driven on the falling edge
            @(negedge clk);
            check_row(i, rows[i]); // one rising edge later
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

// free running clock and power-on reset for the testbench
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o); // 10 edges with reset low
        @(negedge clk_o);
        rst_n_o = 1'b1;               // released away from the sampling edge
    end

endmodule

// ==== verilog.f ====
source/bpu_pkg.sv
source/bpu_table.sv
source/bpu_btb.sv
source/bpu_dir_pred.sv
source/bpu_ras.sv
source/bpu_pc_gen.sv
source/bpu.sv
test/tb_clk_gen.sv
test/tb_bpu.sv
